/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rename core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module rename_core_tb -o rename_core_sim \
    && ./obj_dir/rename_core_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

cat sim.log

grep -q "All tests passed!" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

/* source/alloc_if.sv */
`timescale 1ns/1ps

interface alloc_if import rename_types_pkg::*; ();

    // dispatch accepted this cycle
    logic     fire;
    // destination other than x0
    logic     needs_rd;

    // lowest free tag and whether one exists
    logic     avail;
    phy_reg_t new_phy;

    // current speculative mapping of the destination
    phy_reg_t old_phy;

    modport rob (
        output fire, needs_rd,
        input  avail, new_phy, old_phy
    );

    modport free (
        input  fire, needs_rd,
        output avail, new_phy
    );

    modport rat (
        input  fire, needs_rd, new_phy,
        output old_phy
    );

endinterface

/* source/back_rat.sv */
`timescale 1ns/1ps

module back_rat import core_cfg_pkg::*, rename_types_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    retire_if.sink     retire,
    output map_table_t committed_map
);

    // mapping as seen by retired instructions only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                committed_map[i] <= phy_reg_t'(i);
            end
        end else if (retire.valid && retire.has_rd) begin
            committed_map[retire.rd_arch] <= retire.new_phy;
        end
    end

endmodule

/* source/core_cfg_pkg.sv */
package core_cfg_pkg;

    // architectural and physical register spaces
    localparam int ARCH_REGS = 32;
    localparam int PHY_REGS = 64;

    // reorder buffer slots
    localparam int ROB_DEPTH = 16;

    // program counter width
    localparam int ADDR_WIDTH = 32;

    // index widths derived from the counts
    localparam int ARCH_WIDTH = $clog2(ARCH_REGS);
    localparam int PHY_WIDTH = $clog2(PHY_REGS);
    localparam int ROB_WIDTH = $clog2(ROB_DEPTH);

endpackage

/* source/free_list.sv */
`timescale 1ns/1ps

module free_list import core_cfg_pkg::*, rename_types_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  flush,
    alloc_if.free alloc,
    retire_if.sink retire
);

    // set bit means the tag is in use
    logic [PHY_REGS-1:0] alloc_map;
    logic [PHY_REGS-1:0] commit_map;
    logic [PHY_REGS-1:0] alloc_next;

    // lowest clear bit wins, scan from the top down
    always_comb begin
        alloc.avail = 1'b0;
        alloc.new_phy = '0;
        for (int i = PHY_REGS - 1; i >= 0; i--) begin
            if (!alloc_map[i]) begin
                alloc.avail = 1'b1;
                alloc.new_phy = phy_reg_t'(i);
            end
        end
    end

    // allocation and release touch different bits
    always_comb begin
        alloc_next = alloc_map;
        if (alloc.fire && alloc.needs_rd) begin
            alloc_next[alloc.new_phy] = 1'b1;
        end
        if (retire.valid && retire.has_rd) begin
            alloc_next[retire.old_phy] = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // tags 0..31 hold the initial identity mapping
            alloc_map <= {{(PHY_REGS - ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};
        end else if (flush) begin
            alloc_map <= commit_map;
        end else begin
            alloc_map <= alloc_next;
        end
    end

    // committed view only moves at retirement
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_map <= {{(PHY_REGS - ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};
        end else if (retire.valid && retire.has_rd) begin
            commit_map[retire.old_phy] <= 1'b0;
            commit_map[retire.new_phy] <= 1'b1;
        end
    end

endmodule

/* source/front_rat.sv */
`timescale 1ns/1ps

module front_rat import core_cfg_pkg::*, rename_types_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    alloc_if.rat       alloc,
    input  map_table_t committed_map,
    input  arch_reg_t  rs1_arch,
    input  arch_reg_t  rs2_arch,
    input  arch_reg_t  rd_arch,
    output phy_reg_t   rs1_phy,
    output phy_reg_t   rs2_phy
);

    // speculative arch to physical mapping
    map_table_t spec_map;

    // source lookup sees the mapping before this cycle's write
    assign rs1_phy = spec_map[rs1_arch];
    assign rs2_phy = spec_map[rs2_arch];

    // previous owner of rd, kept by the ROB for release
    assign alloc.old_phy = spec_map[rd_arch];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // identity map with arch reg i in phy reg i
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= phy_reg_t'(i);
            end
        end else if (flush) begin
            // roll back to the committed view
            spec_map <= committed_map;
        end else if (alloc.fire && alloc.needs_rd) begin
            spec_map[rd_arch] <= alloc.new_phy;
        end
    end

endmodule

/* source/rename_core.sv */
`timescale 1ns/1ps

module rename_core import rename_types_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // dispatch
    input  logic      dispatch_valid,
    input  addr_t     dispatch_pc,
    input  arch_reg_t dispatch_rs1,
    input  arch_reg_t dispatch_rs2,
    input  arch_reg_t dispatch_rd,
    output logic      dispatch_ready,
    output phy_reg_t  rs1_phy,
    output phy_reg_t  rs2_phy,
    output phy_reg_t  rd_phy,
    output rob_id_t   rob_id,
    // completion
    input  logic      complete_valid,
    input  rob_id_t   complete_rob_id,
    input  logic      complete_mispredict,
    input  addr_t     complete_target,
    // retirement
    output logic      retire_valid,
    output addr_t     retire_pc,
    output arch_reg_t retire_rd,
    output phy_reg_t  retire_rd_phy,
    // redirect
    output logic      redirect_valid,
    output addr_t     redirect_pc
);

    alloc_if  alloc_bus ();
    retire_if retire_bus ();

    map_table_t committed_map;
    logic       flush;

    // tag offered to the destination this cycle
    assign rd_phy = alloc_bus.new_phy;

    front_rat front_rat_i (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .alloc         (alloc_bus),
        .committed_map (committed_map),
        .rs1_arch      (dispatch_rs1),
        .rs2_arch      (dispatch_rs2),
        .rd_arch       (dispatch_rd),
        .rs1_phy       (rs1_phy),
        .rs2_phy       (rs2_phy)
    );

    free_list free_list_i (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .alloc  (alloc_bus),
        .retire (retire_bus)
    );

    back_rat back_rat_i (
        .clk           (clk),
        .rst           (rst),
        .retire        (retire_bus),
        .committed_map (committed_map)
    );

    reorder_buffer reorder_buffer_i (
        .clk                 (clk),
        .rst                 (rst),
        .alloc               (alloc_bus),
        .retire_port         (retire_bus),
        .dispatch_valid      (dispatch_valid),
        .dispatch_pc         (dispatch_pc),
        .dispatch_rd         (dispatch_rd),
        .dispatch_ready      (dispatch_ready),
        .rob_id              (rob_id),
        .complete_valid      (complete_valid),
        .complete_rob_id     (complete_rob_id),
        .complete_mispredict (complete_mispredict),
        .complete_target     (complete_target),
        .retire_valid        (retire_valid),
        .retire_pc           (retire_pc),
        .retire_rd           (retire_rd),
        .retire_rd_phy       (retire_rd_phy),
        .redirect_valid      (redirect_valid),
        .redirect_pc         (redirect_pc),
        .flush               (flush)
    );

endmodule

/* source/rename_types_pkg.sv */
package rename_types_pkg;

    import core_cfg_pkg::*;

    // register indices and tags
    typedef logic [ARCH_WIDTH-1:0] arch_reg_t;
    typedef logic [PHY_WIDTH-1:0] phy_reg_t;

    // reorder buffer slot index
    typedef logic [ROB_WIDTH-1:0] rob_id_t;

    // instruction address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // whole alias table with one tag per arch register
    typedef phy_reg_t [ARCH_REGS-1:0] map_table_t;

    // one reorder buffer slot
    typedef struct packed {
        addr_t     pc;
        arch_reg_t rd_arch;
        logic      has_rd;
        // tag given to rd at dispatch
        phy_reg_t  new_phy;
        // tag rd held before, released at retire
        phy_reg_t  old_phy;
        logic      done;
        logic      mispredict;
        addr_t     target;
    } rob_entry_t;

endpackage

/* source/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer import core_cfg_pkg::*, rename_types_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    alloc_if.rob      alloc,
    retire_if.rob     retire_port,
    // dispatch side
    input  logic      dispatch_valid,
    input  addr_t     dispatch_pc,
    input  arch_reg_t dispatch_rd,
    output logic      dispatch_ready,
    output rob_id_t   rob_id,
    // completion reports from execution
    input  logic      complete_valid,
    input  rob_id_t   complete_rob_id,
    input  logic      complete_mispredict,
    input  addr_t     complete_target,
    // registered retire and redirect
    output logic      retire_valid,
    output addr_t     retire_pc,
    output arch_reg_t retire_rd,
    output phy_reg_t  retire_rd_phy,
    output logic      redirect_valid,
    output addr_t     redirect_pc,
    output logic      flush
);

    rob_entry_t rob_mem [ROB_DEPTH];

    rob_id_t head;
    rob_id_t tail;
    // one extra bit so a full buffer is distinct from empty
    logic [ROB_WIDTH:0] count;

    logic       full;
    logic       retire_fire;
    logic       retire_flush;
    rob_entry_t head_entry;

    assign full = (count == (ROB_WIDTH + 1)'(ROB_DEPTH));
    assign head_entry = rob_mem[head];

    // x0 writes are dropped, so no tag is needed
    assign alloc.needs_rd = (dispatch_rd != '0);

    // hold dispatch while full, flushing or out of tags
    assign dispatch_ready = !full && !flush && (alloc.avail || !alloc.needs_rd);
    assign alloc.fire = dispatch_valid && dispatch_ready;
    assign rob_id = tail;

    // head leaves once its completion has been seen
    assign retire_fire = (count != '0) && head_entry.done;
    assign retire_flush = retire_fire && head_entry.mispredict;

    // retire port acts at the retire edge itself
    assign retire_port.valid = retire_fire;
    assign retire_port.rd_arch = head_entry.rd_arch;
    assign retire_port.has_rd = head_entry.has_rd;
    assign retire_port.new_phy = head_entry.new_phy;
    assign retire_port.old_phy = head_entry.old_phy;

    // slot storage where a dispatch write wins over a stale completion
    always_ff @(posedge clk) begin
        if (complete_valid) begin
            rob_mem[complete_rob_id].done <= 1'b1;
            rob_mem[complete_rob_id].mispredict <= complete_mispredict;
            rob_mem[complete_rob_id].target <= complete_target;
        end
        if (alloc.fire) begin
            rob_mem[tail] <= '{
                pc:         dispatch_pc,
                rd_arch:    dispatch_rd,
                has_rd:     alloc.needs_rd,
                new_phy:    alloc.new_phy,
                old_phy:    alloc.old_phy,
                done:       1'b0,
                mispredict: 1'b0,
                target:     '0
            };
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else if (retire_flush) begin
            // everything younger than the branch is discarded
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc.fire) begin
                tail <= tail + 1'b1;
            end
            if (retire_fire) begin
                head <= head + 1'b1;
            end
            unique case ({alloc.fire, retire_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // strobes one cycle after the retire edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid <= 1'b0;
            redirect_valid <= 1'b0;
            flush <= 1'b0;
        end else begin
            retire_valid <= retire_fire;
            redirect_valid <= retire_flush;
            flush <= retire_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_fire) begin
            retire_pc <= head_entry.pc;
            retire_rd <= head_entry.rd_arch;
            retire_rd_phy <= head_entry.new_phy;
            redirect_pc <= head_entry.target;
        end
    end

endmodule

/* source/retire_if.sv */
`timescale 1ns/1ps

interface retire_if import rename_types_pkg::*; ();

    // one instruction leaving the head this edge
    logic      valid;
    arch_reg_t rd_arch;
    logic      has_rd;
    phy_reg_t  new_phy;
    phy_reg_t  old_phy;

    modport rob (
        output valid, rd_arch, has_rd, new_phy, old_phy
    );

    modport sink (
        input  valid, rd_arch, has_rd, new_phy, old_phy
    );

endinterface

/* verification/rename_core_tb.sv */
`timescale 1ns/1ps

module rename_core_tb import core_cfg_pkg::*, rename_types_pkg::*; ();

    localparam int CLK_HALF = 4;
    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT = 40;
    localparam int ROWS = 40;
    localparam int FILL_ROWS = 15;

    typedef enum logic [1:0] {OP_DISPATCH, OP_COMPLETE, OP_READY} op_t;

    // one operation of the stimulus table
    typedef struct packed {
        op_t       op;
        addr_t     pc;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        rob_id_t   id;
        logic      mispredict;
        addr_t     target;
        logic      ready;
    } row_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      dispatch_valid;
    addr_t     dispatch_pc;
    arch_reg_t dispatch_rs1;
    arch_reg_t dispatch_rs2;
    arch_reg_t dispatch_rd;
    logic      dispatch_ready;
    phy_reg_t  rs1_phy;
    phy_reg_t  rs2_phy;
    phy_reg_t  rd_phy;
    rob_id_t   rob_id;
    logic      complete_valid;
    rob_id_t   complete_rob_id;
    logic      complete_mispredict;
    addr_t     complete_target;
    logic      retire_valid;
    addr_t     retire_pc;
    arch_reg_t retire_rd;
    phy_reg_t  retire_rd_phy;
    logic      redirect_valid;
    addr_t     redirect_pc;

    // reference model state
    map_table_t          spec_map;
    map_table_t          commit_map;
    logic [PHY_REGS-1:0] spec_used;
    logic [PHY_REGS-1:0] commit_used;
    rob_entry_t          rob_model [ROB_DEPTH];
    rob_id_t             m_head;
    rob_id_t             m_tail;
    int                  m_count;

    row_t   table_rows [ROWS];
    int     row_count;
    int     errors;
    int     checks;
    bit     timed_out;
    integer seed;

    always #CLK_HALF clk = ~clk;

    rename_core dut_i (.*);

    task automatic check_phy(input string what, input phy_reg_t got, input phy_reg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_rob_id(input string what, input rob_id_t got, input rob_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_retire(input arch_reg_t got_rd, input arch_reg_t exp_rd,
                                input phy_reg_t got_phy, input phy_reg_t exp_phy,
                                input addr_t got_pc, input addr_t exp_pc);
        checks++;
        if (got_rd !== exp_rd || got_phy !== exp_phy || got_pc !== exp_pc) begin
            errors++;
            $display("ERR %0t: retired pc %h rd %0d tag %0d, expected pc %h rd %0d tag %0d",
                     $time, got_pc, got_rd, got_phy, exp_pc, exp_rd, exp_phy);
        end
    endtask

    task automatic check_redirect(input logic got_valid, input addr_t got_pc,
                                  input addr_t exp_pc);
        checks++;
        if (got_valid !== 1'b1 || got_pc !== exp_pc) begin
            errors++;
            $display("ERR %0t: redirect valid %b pc %h, expected pc %h",
                     $time, got_valid, got_pc, exp_pc);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        $display("timeout after %0d cycles while waiting for %s", TIMEOUT, what);
    endtask

    task automatic queue_dispatch(input int pc, input int rs1, input int rs2, input int rd);
        row_t row;
        row = '0;
        row.op = OP_DISPATCH;
        row.pc = addr_t'(pc);
        row.rs1 = arch_reg_t'(rs1);
        row.rs2 = arch_reg_t'(rs2);
        row.rd = arch_reg_t'(rd);
        table_rows[row_count] = row;
        row_count++;
    endtask

    task automatic queue_completion(input int id, input int mispredict, input int target);
        row_t row;
        row = '0;
        row.op = OP_COMPLETE;
        row.id = rob_id_t'(id);
        row.mispredict = (mispredict != 0);
        row.target = addr_t'(target);
        table_rows[row_count] = row;
        row_count++;
    endtask

    task automatic expect_ready_row(input int ready);
        row_t row;
        row = '0;
        row.op = OP_READY;
        row.ready = (ready != 0);
        table_rows[row_count] = row;
        row_count++;
    endtask

    task automatic build_table();
        int r;
        row_count = 0;
        expect_ready_row(1);
        // dependent chain on x1..x3
        queue_dispatch(32'h100, 1, 2, 1);
        queue_dispatch(32'h104, 1, 1, 2);
        queue_dispatch(32'h108, 2, 1, 1);
        queue_dispatch(32'h10c, 1, 3, 3);
        // retire stays in order under reverse completion
        queue_completion(3, 0, 0);
        queue_completion(2, 0, 0);
        queue_completion(1, 0, 0);
        queue_completion(0, 0, 0);
        // should reuse the freed tag 1
        queue_dispatch(32'h110, 5, 1, 5);
        queue_completion(4, 0, 0);
        // branch at rob 5 with two younger ones done first
        queue_dispatch(32'h114, 6, 5, 6);
        queue_dispatch(32'h118, 6, 6, 7);
        queue_dispatch(32'h11c, 7, 0, 6);
        queue_completion(7, 0, 0);
        queue_completion(6, 0, 0);
        queue_completion(5, 1, 32'h400);
        queue_dispatch(32'h400, 6, 7, 7);
        // fill the ROB up to its depth
        for (int i = 0; i < FILL_ROWS; i++) begin
            r = $random(seed);
            queue_dispatch(32'h404 + 4 * i, r & 31, (r >> 8) & 31,
                           1 + ((r & 32'h7fff_ffff) % 31));
        end
        expect_ready_row(0);
        queue_completion(0, 0, 0);
        expect_ready_row(1);
    endtask

    task automatic reset_model();
        for (int i = 0; i < ARCH_REGS; i++) begin
            spec_map[i] = phy_reg_t'(i);
        end
        commit_map = spec_map;
        spec_used = '0;
        spec_used[ARCH_REGS-1:0] = '1;
        commit_used = spec_used;
        m_head = '0;
        m_tail = '0;
        m_count = 0;
    endtask

    function automatic phy_reg_t lowest_free(input logic [PHY_REGS-1:0] used);
        phy_reg_t tag;
        logic     found;
        tag = '0;
        found = 1'b0;
        for (int i = 0; i < PHY_REGS; i++) begin
            if (!found && !used[i]) begin
                found = 1'b1;
                tag = phy_reg_t'(i);
            end
        end
        return tag;
    endfunction

    task automatic wait_retire();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!retire_valid && cycles < TIMEOUT);
        if (!retire_valid) begin
            report_timeout("retire_valid");
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!dispatch_ready && cycles < TIMEOUT);
        if (!dispatch_ready) begin
            report_timeout("dispatch_ready");
        end
    endtask

    task automatic apply_dispatch(input row_t row);
        rob_entry_t ent;
        phy_reg_t   tag;
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch_pc <= row.pc;
        dispatch_rs1 <= row.rs1;
        dispatch_rs2 <= row.rs2;
        dispatch_rd <= row.rd;
        wait_ready();
        if (timed_out) begin
            return;
        end
        tag = lowest_free(spec_used);
        check_phy("rs1_phy", rs1_phy, spec_map[row.rs1]);
        check_phy("rs2_phy", rs2_phy, spec_map[row.rs2]);
        check_phy("rd_phy", rd_phy, tag);
        check_rob_id("rob_id", rob_id, m_tail);
        @(posedge clk);
        dispatch_valid <= 1'b0;
        ent = '0;
        ent.pc = row.pc;
        ent.rd_arch = row.rd;
        ent.has_rd = (row.rd != '0);
        ent.new_phy = tag;
        ent.old_phy = spec_map[row.rd];
        rob_model[m_tail] = ent;
        if (ent.has_rd) begin
            spec_map[row.rd] = tag;
            spec_used[tag] = 1'b1;
        end
        m_tail = rob_id_t'(m_tail + 1);
        m_count++;
    endtask

    task automatic retire_model(input rob_entry_t ent);
        if (ent.has_rd) begin
            commit_map[ent.rd_arch] = ent.new_phy;
            spec_used[ent.old_phy] = 1'b0;
            commit_used[ent.old_phy] = 1'b0;
            commit_used[ent.new_phy] = 1'b1;
        end
    endtask

    task automatic apply_completion(input row_t row);
        rob_entry_t head;
        @(posedge clk);
        complete_valid <= 1'b1;
        complete_rob_id <= row.id;
        complete_mispredict <= row.mispredict;
        complete_target <= row.target;
        @(posedge clk);
        complete_valid <= 1'b0;
        rob_model[row.id].done = 1'b1;
        rob_model[row.id].mispredict = row.mispredict;
        rob_model[row.id].target = row.target;
        // drain every done entry from the head in order
        while (!timed_out && m_count > 0 && rob_model[m_head].done) begin
            head = rob_model[m_head];
            wait_retire();
            if (timed_out) begin
                break;
            end
            check_retire(retire_rd, head.rd_arch, retire_rd_phy, head.new_phy,
                         retire_pc, head.pc);
            retire_model(head);
            if (head.mispredict) begin
                check_redirect(redirect_valid, redirect_pc, head.target);
                check_flag("dispatch_ready during flush", dispatch_ready, 1'b0);
                // speculative state falls back to the committed one
                spec_map = commit_map;
                spec_used = commit_used;
                m_head = '0;
                m_tail = '0;
                m_count = 0;
                repeat (4) begin
                    @(negedge clk);
                    check_flag("retire_valid after flush", retire_valid, 1'b0);
                    check_flag("redirect_valid after flush", redirect_valid, 1'b0);
                end
            end else begin
                check_flag("redirect_valid", redirect_valid, 1'b0);
                m_head = rob_id_t'(m_head + 1);
                m_count--;
            end
        end
    endtask

    task automatic apply_ready_check(input row_t row);
        @(negedge clk);
        check_flag("dispatch_ready", dispatch_ready, row.ready);
    endtask

    initial begin
        seed = 66;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_pc = '0;
        dispatch_rs1 = '0;
        dispatch_rs2 = '0;
        dispatch_rd = '0;
        complete_valid = 1'b0;
        complete_rob_id = '0;
        complete_mispredict = 1'b0;
        complete_target = '0;
        reset_model();
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("retire_valid after reset", retire_valid, 1'b0);
        check_flag("redirect_valid after reset", redirect_valid, 1'b0);
        for (int r = 0; r < row_count && !timed_out; r++) begin
            case (table_rows[r].op)
                OP_DISPATCH: apply_dispatch(table_rows[r]);
                OP_COMPLETE: apply_completion(table_rows[r]);
                default: apply_ready_check(table_rows[r]);
            endcase
        end
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/core_cfg_pkg.sv
source/rename_types_pkg.sv
source/alloc_if.sv
source/retire_if.sv
source/front_rat.sv
source/free_list.sv
source/back_rat.sv
source/reorder_buffer.sv
source/rename_core.sv
verification/rename_core_tb.sv
